/* hw/seg7_defs.svh */
`ifndef SEG7_DEFS_SVH
`define SEG7_DEFS_SVH

// Register window of the display peripheral.
// Eight word-aligned registers, one byte per digit.
`define SEG7_BASE_ADDR 32'hFFFF_0100

// Address bits 31:5 take part in the window decode.
`define SEG7_ADDR_MASK 32'hFFFF_FFE0

// Number of multiplexed digits on the display.
`define SEG7_NUM_DIGITS 8

// Default clock cycles spent on each digit before the scanner moves on.
`define SEG7_SCAN_DIV 1024

`endif

/* hw/seg7_pkg.sv */
`default_nettype none

package seg7_pkg;

    // Bus operation seen on the strobes in the current cycle.
    typedef enum logic [1:0] {
        op_idle  = 2'b00,  // No strobe is raised.
        op_read  = 2'b01,  // Read strobe is raised.
        op_write = 2'b10   // Write strobe is raised.
    } bus_op_e;

    // One register byte per digit, as the bus master writes it.
    typedef struct packed {
        logic [1:0] spare;  // Stored and read back, not shown.
        logic       blank;  // Turns all segments of the digit off.
        logic       dp;     // Lights the decimal point.
        logic [3:0] value;  // Hex value shown through the font.
    } digit_byte_t;

    // Position of a digit on the display, 0 is the rightmost anode.
    typedef logic [2:0] digit_idx_t;

endpackage

`default_nettype wire

/* hw/seg7_digit_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Carries the digit currently being scanned from the scanner to the encoder.
// The display never stalls, so there is no ready signal back.
interface seg7_digit_if (
    input wire logic sys_clk
);
    import seg7_pkg::*;

    digit_idx_t  idx;    // Anode position of the digit.
    digit_byte_t digit;  // Register byte of that position.
    logic        valid;  // Low from reset until the first scan tick.

    // Scanner side.
    modport scan_mp (
        input  sys_clk,
        output idx,
        output digit,
        output valid
    );

    // Encoder side.
    modport encode_mp (
        input sys_clk,
        input idx,
        input digit,
        input valid
    );

endinterface

`default_nettype wire

/* hw/mmio_seg7.sv */
`timescale 1ns/1ps
`default_nettype none

`include "seg7_defs.svh"

// Bus slave for the eight digit registers.
// A strobe inside the window is answered with a one-cycle done pulse in the
// following cycle, and a write lands on the same edge as that pulse.
module mmio_seg7 (
    input  wire logic                  sys_clk,
    input  wire logic                  rst_n,
    input  wire logic                  mmio_read,
    input  wire logic                  mmio_write,
    input  wire logic [31:0]           mmio_addr,
    input  wire logic [31:0]           mmio_write_data,
    output logic                       mmio_work,
    output logic                       mmio_done,
    output logic [31:0]                mmio_read_data,
    output seg7_pkg::digit_byte_t      digits [`SEG7_NUM_DIGITS]
);
    import seg7_pkg::*;

    bus_op_e    bus_op;     // Operation requested by the master.
    logic       in_window;  // Address falls inside the register window.
    logic       accept;     // Strobe is taken on this edge.
    digit_idx_t reg_sel;    // Register picked by address bits 4:2.

    always_comb begin
        if (mmio_write) begin
            bus_op = op_write;
        end else if (mmio_read) begin
            bus_op = op_read;
        end else begin
            bus_op = op_idle;
        end
    end

    assign in_window = (mmio_addr & `SEG7_ADDR_MASK) == (`SEG7_BASE_ADDR & `SEG7_ADDR_MASK);
    assign reg_sel   = mmio_addr[4:2];  // Word-aligned, byte lanes 1:0 ignored.

    // Work follows the strobe directly, so the master sees it in the same cycle.
    assign mmio_work = in_window && (bus_op != op_idle);

    // The done cycle itself does not start a second access.
    assign accept = mmio_work && !mmio_done;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            mmio_done      <= 1'b0;
            mmio_read_data <= '0;
        end else begin
            mmio_done <= accept;  // Exactly one cycle, the master drops its strobe next.
            if (accept && bus_op == op_read) begin
                mmio_read_data <= {24'b0, digits[reg_sel]};  // Zero-extended byte.
            end else begin
                mmio_read_data <= '0;  // Read data is only valid during done.
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `SEG7_NUM_DIGITS; i++) begin
                digits[i] <= '0;
            end
        end else if (accept && bus_op == op_write) begin
            digits[reg_sel] <= digit_byte_t'(mmio_write_data[7:0]);  // Spare bits kept too.
        end
    end

    // A done pulse lasts one cycle and always answers a strobe from the cycle before.
    a_done_pulse: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
        mmio_done |-> !$past(mmio_done) && ($past(bus_op) != op_idle)
    );

    // The master raises at most one strobe at a time.
    a_strobe_excl: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
        !(mmio_read && mmio_write)
    );

endmodule

`default_nettype wire

/* hw/seg7_scan.sv */
`timescale 1ns/1ps
`default_nettype none

`include "seg7_defs.svh"

// Scan stage of the display pipeline.
// A down-counter makes one tick every scan_div cycles; on each tick the
// current digit is handed to the encoder and the index moves on.
module seg7_scan #(
    parameter int unsigned scan_div = `SEG7_SCAN_DIV
) (
    input  wire logic                  sys_clk,
    input  wire logic                  rst_n,
    input  seg7_pkg::digit_byte_t      digits [`SEG7_NUM_DIGITS],
    seg7_digit_if.scan_mp              out
);
    import seg7_pkg::*;

    // A divider of one still needs a one-bit counter.
    localparam int unsigned cnt_w = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam logic [cnt_w-1:0] cnt_load = cnt_w'(scan_div - 1);

    logic [cnt_w-1:0] div_cnt;   // Cycles left on the current digit.
    logic             tick;      // Last cycle of the current digit.
    digit_idx_t       scan_idx;  // Next digit to hand over.

    assign tick = (div_cnt == '0);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            div_cnt <= cnt_load;  // First tick comes scan_div cycles after reset.
        end else if (tick) begin
            div_cnt <= cnt_load;
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    // Index wraps from 7 back to 0 through the natural 3-bit overflow.
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            scan_idx <= '0;
        end else if (tick) begin
            scan_idx <= scan_idx + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            out.idx   <= '0;
            out.digit <= '0;
            out.valid <= 1'b0;  // Keeps the pins dark until the first tick.
        end else if (tick) begin
            out.idx   <= scan_idx;
            out.digit <= digits[scan_idx];  // Byte sampled once per visit.
            out.valid <= 1'b1;
        end
    end

    // Neither the internal index nor the handed-over one moves between ticks.
    a_idx_on_tick: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
        !tick |=> $stable(scan_idx) && $stable(out.idx)
    );

endmodule

`default_nettype wire

/* hw/seg7_encode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "seg7_defs.svh"

// Encode stage of the display pipeline.
// Turns the scanned byte into active-low anode and segment pins for a
// common-anode display.
module seg7_encode (
    input  wire logic                          sys_clk,
    input  wire logic                          rst_n,
    seg7_digit_if.encode_mp                    in,
    output logic [`SEG7_NUM_DIGITS-1:0]        seg7_anode_pin,
    output logic [7:0]                         seg7_seg_pin
);
    import seg7_pkg::*;

    logic [6:0]                  glyph;       // Segments g to a, high when lit.
    logic [7:0]                  seg_next;    // Pin levels for the next cycle.
    logic [`SEG7_NUM_DIGITS-1:0] anode_next;

    // Standard hex font.
    always_comb begin
        case (in.digit.value)
            4'h0: glyph = 7'h3F;
            4'h1: glyph = 7'h06;
            4'h2: glyph = 7'h5B;
            4'h3: glyph = 7'h4F;
            4'h4: glyph = 7'h66;
            4'h5: glyph = 7'h6D;
            4'h6: glyph = 7'h7D;
            4'h7: glyph = 7'h07;
            4'h8: glyph = 7'h7F;
            4'h9: glyph = 7'h6F;
            4'hA: glyph = 7'h77;
            4'hB: glyph = 7'h7C;  // Lower case b.
            4'hC: glyph = 7'h39;
            4'hD: glyph = 7'h5E;  // Lower case d.
            4'hE: glyph = 7'h79;
            default: glyph = 7'h71;
        endcase
    end

    // Blank clears the glyph only, the decimal point keeps following dp.
    assign seg_next   = ~{in.digit.dp, (in.digit.blank ? 7'b0 : glyph)};
    assign anode_next = ~(`SEG7_NUM_DIGITS'(1) << in.idx);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            seg7_anode_pin <= '1;  // All anodes off.
            seg7_seg_pin   <= '1;  // All segments off.
        end else if (in.valid) begin
            seg7_anode_pin <= anode_next;
            seg7_seg_pin   <= seg_next;
        end
    end

    // Only one digit is ever driven at a time.
    a_one_anode: assert property (
        @(posedge in.sys_clk) disable iff (!rst_n)
        $onehot0(~seg7_anode_pin)
    );

endmodule

`default_nettype wire

/* hw/seg7_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "seg7_defs.svh"

// Memory-mapped eight-digit seven-segment display.
// Bus slave and register bank, then scanner, then encoder.
module seg7_top #(
    parameter int unsigned scan_div = `SEG7_SCAN_DIV
) (
    input  wire logic                   sys_clk,
    input  wire logic                   rst_n,
    input  wire logic                   mmio_read,
    input  wire logic                   mmio_write,
    input  wire logic [31:0]            mmio_addr,
    input  wire logic [31:0]            mmio_write_data,
    output logic                        mmio_work,
    output logic                        mmio_done,
    output logic [31:0]                 mmio_read_data,
    output logic [`SEG7_NUM_DIGITS-1:0] seg7_anode_pin,
    output logic [7:0]                  seg7_seg_pin
);
    import seg7_pkg::*;

    digit_byte_t digits [`SEG7_NUM_DIGITS];  // Register bank contents.

    seg7_digit_if scan_if (
        .sys_clk (sys_clk)
    );

    mmio_seg7 mmio_seg7_i (
        .sys_clk         (sys_clk),
        .rst_n           (rst_n),
        .mmio_read       (mmio_read),
        .mmio_write      (mmio_write),
        .mmio_addr       (mmio_addr),
        .mmio_write_data (mmio_write_data),
        .mmio_work       (mmio_work),
        .mmio_done       (mmio_done),
        .mmio_read_data  (mmio_read_data),
        .digits          (digits)
    );

    seg7_scan #(
        .scan_div (scan_div)
    ) seg7_scan_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .digits  (digits),
        .out     (scan_if.scan_mp)
    );

    seg7_encode seg7_encode_i (
        .sys_clk        (sys_clk),
        .rst_n          (rst_n),
        .in             (scan_if.encode_mp),
        .seg7_anode_pin (seg7_anode_pin),
        .seg7_seg_pin   (seg7_seg_pin)
    );

endmodule

`default_nettype wire

/* test/tb_seg7_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "seg7_defs.svh"

module tb_seg7_top;

    localparam int unsigned scan_div = 4;  // Short scan so a full pass takes few cycles.

    logic        sys_clk;
    logic        rst_n;
    logic        mmio_read;
    logic        mmio_write;
    logic [31:0] mmio_addr;
    logic [31:0] mmio_write_data;
    logic        mmio_work;
    logic        mmio_done;
    logic [31:0] mmio_read_data;
    logic [7:0]  seg7_anode_pin;
    logic [7:0]  seg7_seg_pin;

    // Operations loaded from the test file, one entry per W, R or S line.
    byte         op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    logic        work_q[$];
    logic [7:0]  seg_q[$];  // Eight expected pin bytes per S line.

    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 200;  // Raised once the test file is counted.

    seg7_top #(
        .scan_div (scan_div)
    ) seg7_top_i (
        .sys_clk         (sys_clk),
        .rst_n           (rst_n),
        .mmio_read       (mmio_read),
        .mmio_write      (mmio_write),
        .mmio_addr       (mmio_addr),
        .mmio_write_data (mmio_write_data),
        .mmio_work       (mmio_work),
        .mmio_done       (mmio_done),
        .mmio_read_data  (mmio_read_data),
        .seg7_anode_pin  (seg7_anode_pin),
        .seg7_seg_pin    (seg7_seg_pin)
    );

    initial begin
        sys_clk = 1'b0;
        forever begin
            #10 sys_clk = ~sys_clk;  // 20 ns period.
        end
    end

    always @(posedge sys_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run took more than %0d clock cycles.", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run;
        $display("Test failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Inputs change and outputs are sampled 2 ns after the rising edge.
    task automatic next_cycle;
        @(posedge sys_clk);
        #2;
    endtask

    task automatic bus_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic exp_work,
                              input logic [31:0] exp_rdata);
        int   waited;
        logic got_done;
        got_done        = 1'b0;
        waited          = 0;
        mmio_addr       = addr;
        mmio_write_data = wdata;
        mmio_write      = is_write;
        mmio_read       = !is_write;
        #1;  // Let the combinational work flag settle.
        check_value(mmio_work, exp_work, "work flag at strobe");
        while (!got_done && waited < 4) begin
            next_cycle();
            waited++;
            if (mmio_done) begin
                got_done = 1'b1;
            end else begin
                check_value(mmio_read_data, 32'h0, "read data outside done");
                check_value(mmio_work, exp_work, "work flag while waiting");
            end
        end
        if (exp_work) begin
            check_value(got_done, 1'b1, "done pulse within four cycles");
            check_value(mmio_read_data, exp_rdata, $sformatf("read data at %h", addr));
        end else begin
            check_value(got_done, 1'b0, $sformatf("no done for address %h", addr));
        end
        next_cycle();  // The strobe stays up until the cycle after done.
        check_value(mmio_done, 1'b0, "done lasts one cycle");
        check_value(mmio_read_data, 32'h0, "read data after done");
        mmio_read  = 1'b0;
        mmio_write = 1'b0;
    endtask

    // Waits for a fresh visit of digit 0, then follows the anodes through 0 to 7.
    task automatic check_scan(input int base);
        int         guard;
        logic [7:0] exp_anode;
        logic [7:0] prev_anode;
        repeat (2) next_cycle();  // A write that just finished must reach the scanner first.
        guard = 0;
        while (seg7_anode_pin == 8'hFE && guard < scan_div * 16) begin
            next_cycle();
            guard++;
        end
        while (seg7_anode_pin != 8'hFE && guard < scan_div * 32) begin
            next_cycle();
            guard++;
        end
        if (seg7_anode_pin != 8'hFE) begin
            $display("The scan never reached digit 0 at %0t.", $time);
            abort_run();
        end
        for (int k = 0; k < `SEG7_NUM_DIGITS; k++) begin
            exp_anode = ~(8'h01 << k);
            if (k > 0) begin
                prev_anode = ~(8'h01 << (k - 1));
                guard = 0;
                while (seg7_anode_pin == prev_anode && guard < scan_div * 4) begin
                    next_cycle();
                    guard++;
                end
            end
            check_value(seg7_anode_pin, exp_anode, $sformatf("anode pins for digit %0d", k));
            check_value(seg7_seg_pin, seg_q[base + k],
                        $sformatf("segment pins for digit %0d", k));
        end
    endtask

    task automatic load_tests;
        int         fd;
        int         n;
        int         line_count;
        string      line;
        byte        op_c;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] w;
        logic [7:0]  s [8];
        line_count = 0;
        fd = $fopen("test/seg7_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/seg7_tests.txt for reading.");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            line_count++;
            if (line.len() == 0) continue;
            op_c = line.getc(0);
            if (op_c == "W" || op_c == "R") begin
                n = $sscanf(line, "%c %h %h %h", op_c, a, d, w);
                if (n != 4) begin
                    $display("Line %0d of the test file is malformed.", line_count);
                    abort_run();
                end
                op_q.push_back(op_c);
                addr_q.push_back(a);
                data_q.push_back(d);
                work_q.push_back(w[0]);
            end else if (op_c == "S") begin
                n = $sscanf(line, "%c %h %h %h %h %h %h %h %h", op_c,
                            s[0], s[1], s[2], s[3], s[4], s[5], s[6], s[7]);
                if (n != 9) begin
                    $display("Line %0d of the test file is malformed.", line_count);
                    abort_run();
                end
                op_q.push_back(op_c);
                addr_q.push_back(32'h0);
                data_q.push_back(32'h0);
                work_q.push_back(1'b0);
                for (int i = 0; i < 8; i++) begin
                    seg_q.push_back(s[i]);
                end
            end
        end
        $fclose(fd);
        cycle_limit = line_count * 50 + 200;
    endtask

    initial begin
        int ops_done;
        int seg_base;
        ops_done        = 0;
        seg_base        = 0;
        rst_n           = 1'b0;
        mmio_read       = 1'b0;
        mmio_write      = 1'b0;
        mmio_addr       = 32'h0;
        mmio_write_data = 32'h0;
        load_tests();
        repeat (10) @(posedge sys_clk);
        #2;
        rst_n = 1'b1;
        // Pins stay dark until the scanner hands over its first digit.
        check_value(seg7_anode_pin, 8'hFF, "anode pins after reset");
        check_value(seg7_seg_pin, 8'hFF, "segment pins after reset");
        foreach (op_q[i]) begin
            case (op_q[i])
                "W": bus_access(1'b1, addr_q[i], data_q[i], work_q[i], 32'h0);
                "R": bus_access(1'b0, addr_q[i], 32'h0, work_q[i], data_q[i]);
                default: begin
                    check_scan(seg_base);
                    seg_base += 8;
                end
            endcase
            ops_done++;
        end
        if (ops_done > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("The test file held no operations.");
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+hw
hw/seg7_pkg.sv
hw/seg7_digit_if.sv
hw/mmio_seg7.sv
hw/seg7_scan.sv
hw/seg7_encode.sv
hw/seg7_top.sv
test/tb_seg7_top.sv

/* Bender.yml */
package:
  name: seg7_display

sources:
  # Display peripheral RTL, package first.
  - include_dirs:
      - hw
    files:
      - hw/seg7_pkg.sv
      - hw/seg7_digit_if.sv
      - hw/mmio_seg7.sv
      - hw/seg7_scan.sv
      - hw/seg7_encode.sv
      - hw/seg7_top.sv

  # Self-checking testbench, reads test/seg7_tests.txt.
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_seg7_top.sv

/* test/seg7_tests.txt */
# W addr data work : write, data is the bus word, work is the expected work flag
# R addr data work : read, data is the expected read data
# S p0 .. p7       : expected segment pins of digits 0 to 7 over one scan
# Registers are zero after reset.
R FFFF0100 00000000 1
R FFFF0104 00000000 1
R FFFF0108 00000000 1
R FFFF010C 00000000 1
R FFFF0110 00000000 1
R FFFF0114 00000000 1
R FFFF0118 00000000 1
R FFFF011C 00000000 1
S C0 C0 C0 C0 C0 C0 C0 C0
# Values, decimal point, blank and spare bits.
W FFFF0100 00000001 1
W FFFF0104 00000012 1
W FFFF0108 000000C3 1
W FFFF010C 00000024 1
W FFFF0110 00000035 1
W FFFF0114 0000004A 1
W FFFF0118 FFFFFF8E 1
W FFFF011C 0000001F 1
R FFFF0100 00000001 1
R FFFF0104 00000012 1
R FFFF0108 000000C3 1
R FFFF010C 00000024 1
R FFFF0110 00000035 1
R FFFF0114 0000004A 1
R FFFF0118 0000008E 1
R FFFF011C 0000001F 1
S F9 24 B0 FF 7F 88 86 0E
# Outside the window there is no work and no done.
W FFFF0120 00000055 0
W FFFF00FC 00000055 0
R FFFF0200 00000000 0
R 00000100 00000000 0
R FFFF0100 00000001 1
R FFFF011C 0000001F 1
# The rest of the font.
W FFFF0100 00000000 1
W FFFF0104 00000005 1
W FFFF0108 00000006 1
W FFFF010C 00000007 1
W FFFF0110 00000008 1
W FFFF0114 00000009 1
W FFFF0118 0000000B 1
W FFFF011C 0000000C 1
S C0 92 82 F8 80 90 83 C6
W FFFF0100 0000000D 1
W FFFF0104 0000001D 1
S A1 21 82 F8 80 90 83 C6
